// File: design/addr_gen.sv
`timescale 1ns/10ps

module addr_gen import stream_dma_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   fifo_valid,
  input  data_t  fifo_data,
  output logic   fifo_pop,
  output logic   window_done,
  dma_cfg_if.gen cfg,
  wr_req_if.src  req
);

  beat_cnt_t offset;
  beat_cnt_t next_offset;
  logic      stopped;
  logic      last_beat;
  logic      slot_free;
  logic      out_valid;
  addr_t     out_addr;
  data_t     out_data;

  assign next_offset = offset + 1'b1;
  assign last_beat   = (next_offset >= cfg.window_beats);
  assign slot_free   = !out_valid || req.req_take;

  // No pop in the restart cycle, so the first beat always uses offset zero.
  assign fifo_pop = cfg.run && !cfg.restart && !stopped && fifo_valid && slot_free;

  always_ff @(posedge clk) begin
    if (!rst) begin
      offset      <= '0;
      stopped     <= 1'b0;
      out_valid   <= 1'b0;
      window_done <= 1'b0;
    end else begin
      window_done <= 1'b0;
      if (cfg.restart) begin
        offset  <= '0;
        stopped <= 1'b0;
      end else if (fifo_pop) begin
        offset <= last_beat ? '0 : next_offset;
        if (last_beat && !cfg.wrap) begin
          stopped     <= 1'b1;
          window_done <= 1'b1;
        end
      end
      if (fifo_pop) begin
        out_valid <= 1'b1;
      end else if (req.req_take) begin
        out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fifo_pop) begin
      out_addr <= cfg.base_addr + (addr_t'(offset) << BEAT_SHIFT);
      out_data <= fifo_data;
    end
  end

  assign req.req_valid = out_valid;
  assign req.req_addr  = out_addr;
  assign req.req_data  = out_data;

endmodule

// File: design/axi_wr_issue.sv
`timescale 1ns/10ps

module axi_wr_issue import stream_dma_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  output addr_t     m_axi_awaddr,
  output logic      m_axi_awvalid,
  input  logic      m_axi_awready,
  output data_t     m_axi_wdata,
  output logic      m_axi_wvalid,
  input  logic      m_axi_wready,
  input  axi_resp_t m_axi_bresp,
  input  logic      m_axi_bvalid,
  output logic      resp_ok,
  output logic      resp_err,
  wr_req_if.snk     req
);

  logic             busy;
  logic             aw_done;
  logic             w_done;
  logic             aw_fire;
  logic             w_fire;
  logic             complete;
  logic             take;
  logic [OST_W-1:0] outstanding;
  addr_t            hold_addr;
  data_t            hold_data;

  // ==============================
  // Channel handshakes
  // ==============================
  assign m_axi_awvalid = busy && !aw_done;
  assign m_axi_wvalid  = busy && !w_done;
  assign m_axi_awaddr  = hold_addr;
  assign m_axi_wdata   = hold_data;

  assign aw_fire  = m_axi_awvalid && m_axi_awready;
  assign w_fire   = m_axi_wvalid && m_axi_wready;
  assign complete = busy && (aw_done || aw_fire) && (w_done || w_fire);

  // The holding register reloads in the cycle the last of the two handshakes lands.
  assign take = req.req_valid && (!busy || complete) &&
                (outstanding < OST_W'(MAX_OUTSTANDING));
  assign req.req_take = take;

  always_ff @(posedge clk) begin
    if (!rst) begin
      busy    <= 1'b0;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else if (take) begin
      busy    <= 1'b1;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      if (complete) begin
        busy <= 1'b0;
      end
      if (aw_fire) begin
        aw_done <= 1'b1;
      end
      if (w_fire) begin
        w_done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      hold_addr <= req.req_addr;
      hold_data <= req.req_data;
    end
  end

  // ==============================
  // Responses
  // ==============================
  // bready is tied high, so every bvalid cycle is one completed write.
  always_ff @(posedge clk) begin
    if (!rst) begin
      outstanding <= '0;
      resp_ok     <= 1'b0;
      resp_err    <= 1'b0;
    end else begin
      outstanding <= outstanding + OST_W'(take) - OST_W'(m_axi_bvalid);
      resp_ok     <= m_axi_bvalid && (m_axi_bresp == RESP_OKAY);
      resp_err    <= m_axi_bvalid && (m_axi_bresp != RESP_OKAY);
    end
  end

endmodule

// File: design/credit_fifo.sv
`timescale 1ns/10ps

module credit_fifo import stream_dma_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  in_valid,
  input  data_t in_data,
  output logic  in_credit,
  output logic  fifo_valid,
  output data_t fifo_data,
  input  logic  fifo_pop
);

  data_t                 mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [FIFO_PTR_W:0]   count;

  // The producer only sends against a credit, so a beat is never offered
  // while the buffer is full.
  always_ff @(posedge clk) begin
    if (in_valid) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // ==============================
  // Pointers and fill level
  // ==============================
  always_ff @(posedge clk) begin
    if (!rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (in_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (fifo_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({in_valid, fifo_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Each slot that frees up goes back to the producer as one credit.
  always_ff @(posedge clk) begin
    if (!rst) begin
      in_credit <= 1'b0;
    end else begin
      in_credit <= fifo_pop;
    end
  end

  assign fifo_valid = (count != '0);
  assign fifo_data  = mem[rd_ptr];

endmodule

// File: design/dma_ctrl.sv
`timescale 1ns/10ps

`include "dma_regmap.svh"

module dma_ctrl import stream_dma_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      reg_wen,
  input  reg_addr_t reg_waddr,
  input  reg_data_t reg_wdata,
  input  logic      reg_ren,
  input  reg_addr_t reg_raddr,
  output reg_data_t reg_rdata,
  input  logic      window_done,
  input  logic      resp_ok,
  input  logic      resp_err,
  dma_cfg_if.ctrl   cfg
);

  ctrl_state_t state;
  addr_t       base_addr;
  beat_cnt_t   window_beats;
  logic        wrap_bit;
  logic        enable_bit;
  logic        err_flag;
  logic        restart;
  reg_data_t   wr_count;
  reg_data_t   rd_word;
  logic        mode_wr;

  assign mode_wr = reg_wen && (reg_waddr == `DMA_REG_MODE);

  // ==============================
  // Register writes
  // ==============================
  always_ff @(posedge clk) begin
    if (!rst) begin
      base_addr    <= '0;
      window_beats <= '0;
      wrap_bit     <= 1'b0;
      enable_bit   <= 1'b0;
    end else if (reg_wen) begin
      if (reg_waddr == `DMA_REG_BASE_L) begin
        base_addr[REG_DATA_W-1:0] <= reg_wdata;
      end
      if (reg_waddr == `DMA_REG_BASE_H) begin
        base_addr[ADDR_W-1:REG_DATA_W] <= reg_wdata[ADDR_HI_W-1:0];
      end
      if (reg_waddr == `DMA_REG_WINDOW) begin
        window_beats <= reg_wdata[BEAT_W-1:0];
      end
      if (mode_wr) begin
        wrap_bit   <= reg_wdata[`DMA_MODE_WRAP];
        enable_bit <= reg_wdata[`DMA_MODE_EN];
      end
    end
  end

  // ==============================
  // Run state machine
  // ==============================
  // A MODE write with enable set always starts a fresh window, also from ST_HALT.
  always_ff @(posedge clk) begin
    if (!rst) begin
      state   <= ST_IDLE;
      restart <= 1'b0;
    end else begin
      restart <= mode_wr && reg_wdata[`DMA_MODE_EN];
      if (mode_wr) begin
        state <= reg_wdata[`DMA_MODE_EN] ? ST_RUN : ST_IDLE;
      end else if (state == ST_RUN && window_done) begin
        state <= ST_HALT;
      end
    end
  end

  // Every B handshake counts, whatever its response code.
  always_ff @(posedge clk) begin
    if (!rst) begin
      wr_count <= '0;
      err_flag <= 1'b0;
    end else begin
      if (resp_ok || resp_err) begin
        wr_count <= wr_count + 1'b1;
      end
      if (resp_err) begin
        err_flag <= 1'b1;
      end else if (reg_wen && reg_waddr == `DMA_REG_STATUS) begin
        err_flag <= 1'b0;
      end
    end
  end

  // ==============================
  // Register reads
  // ==============================
  always_comb begin
    rd_word = '0;
    case (reg_raddr)
      `DMA_REG_MODE: begin
        rd_word[`DMA_MODE_WRAP] = wrap_bit;
        rd_word[`DMA_MODE_EN]   = enable_bit;
      end
      `DMA_REG_BASE_L: rd_word = base_addr[REG_DATA_W-1:0];
      `DMA_REG_BASE_H: rd_word[ADDR_HI_W-1:0] = base_addr[ADDR_W-1:REG_DATA_W];
      `DMA_REG_WINDOW: rd_word[BEAT_W-1:0] = window_beats;
      `DMA_REG_STATUS: begin
        rd_word[`DMA_STATUS_HALTED] = (state == ST_HALT);
        rd_word[`DMA_STATUS_ERR]    = err_flag;
        rd_word[`DMA_STATUS_RUN]    = (state == ST_RUN);
      end
      `DMA_REG_COUNT: rd_word = wr_count;
      default: rd_word = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      reg_rdata <= '0;
    end else if (reg_ren) begin
      reg_rdata <= rd_word;
    end
  end

  assign cfg.base_addr    = base_addr;
  assign cfg.window_beats = window_beats;
  assign cfg.wrap         = wrap_bit;
  assign cfg.run          = (state == ST_RUN);
  assign cfg.restart      = restart;

endmodule

// File: design/dma_ifs.sv
`timescale 1ns/10ps

// Window setup and run control, from the register block to the address generator.
interface dma_cfg_if import stream_dma_pkg::*; ();
  addr_t     base_addr;
  beat_cnt_t window_beats;
  logic      wrap;
  logic      run;
  logic      restart;

  modport ctrl (output base_addr, output window_beats, output wrap, output run,
                output restart);
  modport gen  (input base_addr, input window_beats, input wrap, input run,
                input restart);
endinterface

// One addressed write beat.
// The source keeps valid, address and data stable until valid and take meet.
interface wr_req_if import stream_dma_pkg::*; ();
  logic  req_valid;
  addr_t req_addr;
  data_t req_data;
  logic  req_take;

  modport src (output req_valid, output req_addr, output req_data, input req_take);
  modport snk (input req_valid, input req_addr, input req_data, output req_take);
endinterface

// File: design/stream_axi_writer.sv
`timescale 1ns/10ps

module stream_axi_writer import stream_dma_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      reg_wen,
  input  reg_addr_t reg_waddr,
  input  reg_data_t reg_wdata,
  input  logic      reg_ren,
  input  reg_addr_t reg_raddr,
  output reg_data_t reg_rdata,
  input  logic      in_valid,
  input  data_t     in_data,
  output logic      in_credit,
  output addr_t     m_axi_awaddr,
  output logic      m_axi_awvalid,
  input  logic      m_axi_awready,
  output data_t     m_axi_wdata,
  output logic      m_axi_wvalid,
  input  logic      m_axi_wready,
  input  axi_resp_t m_axi_bresp,
  input  logic      m_axi_bvalid
);

  logic  fifo_valid;
  data_t fifo_data;
  logic  fifo_pop;
  logic  window_done;
  logic  resp_ok;
  logic  resp_err;

  dma_cfg_if cfg_bus ();
  wr_req_if  req_bus ();

  // ==============================
  // Datapath
  // ==============================
  credit_fifo u_fifo (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .in_credit  (in_credit),
    .fifo_valid (fifo_valid),
    .fifo_data  (fifo_data),
    .fifo_pop   (fifo_pop)
  );

  addr_gen u_addr_gen (
    .clk         (clk),
    .rst         (rst),
    .fifo_valid  (fifo_valid),
    .fifo_data   (fifo_data),
    .fifo_pop    (fifo_pop),
    .window_done (window_done),
    .cfg         (cfg_bus.gen),
    .req         (req_bus.src)
  );

  axi_wr_issue u_issue (
    .clk           (clk),
    .rst           (rst),
    .m_axi_awaddr  (m_axi_awaddr),
    .m_axi_awvalid (m_axi_awvalid),
    .m_axi_awready (m_axi_awready),
    .m_axi_wdata   (m_axi_wdata),
    .m_axi_wvalid  (m_axi_wvalid),
    .m_axi_wready  (m_axi_wready),
    .m_axi_bresp   (m_axi_bresp),
    .m_axi_bvalid  (m_axi_bvalid),
    .resp_ok       (resp_ok),
    .resp_err      (resp_err),
    .req           (req_bus.snk)
  );

  // Register block and run control.
  dma_ctrl u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .reg_wen     (reg_wen),
    .reg_waddr   (reg_waddr),
    .reg_wdata   (reg_wdata),
    .reg_ren     (reg_ren),
    .reg_raddr   (reg_raddr),
    .reg_rdata   (reg_rdata),
    .window_done (window_done),
    .resp_ok     (resp_ok),
    .resp_err    (resp_err),
    .cfg         (cfg_bus.ctrl)
  );

endmodule

// File: design/stream_dma_pkg.sv
package stream_dma_pkg;

  // ==============================
  // Widths
  // ==============================
  localparam int unsigned ADDR_W     = 36;
  localparam int unsigned DATA_W     = 64;
  localparam int unsigned BEAT_W     = 24;
  localparam int unsigned REG_ADDR_W = 16;
  localparam int unsigned REG_DATA_W = 32;

  // Upper part of the base address that lives in BASE_H.
  localparam int unsigned ADDR_HI_W = ADDR_W - REG_DATA_W;

  // ==============================
  // Sizing
  // ==============================
  localparam int unsigned BEAT_BYTES      = 8;
  localparam int unsigned BEAT_SHIFT      = $clog2(BEAT_BYTES);
  localparam int unsigned FIFO_DEPTH      = 8;
  localparam int unsigned FIFO_PTR_W      = $clog2(FIFO_DEPTH);
  localparam int unsigned MAX_OUTSTANDING = 4;
  localparam int unsigned OST_W           = $clog2(MAX_OUTSTANDING + 1);

  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [BEAT_W-1:0]     beat_cnt_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [REG_DATA_W-1:0] reg_data_t;
  typedef logic [1:0]            axi_resp_t;

  localparam axi_resp_t RESP_OKAY = 2'b00;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_HALT
  } ctrl_state_t;

endpackage

// File: include/dma_regmap.svh
`ifndef DMA_REGMAP_SVH
`define DMA_REGMAP_SVH

// Register offsets on the control bus.
`define DMA_REG_MODE    16'h0000
`define DMA_REG_BASE_L  16'h0004
`define DMA_REG_BASE_H  16'h0008
`define DMA_REG_WINDOW  16'h000C
`define DMA_REG_STATUS  16'h0010
`define DMA_REG_COUNT   16'h0014

// Bit positions inside MODE and STATUS.
`define DMA_MODE_WRAP      0
`define DMA_MODE_EN        1
`define DMA_STATUS_HALTED  0
`define DMA_STATUS_ERR     1
`define DMA_STATUS_RUN     2

`endif

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module tb_stream_axi_writer -o sim_tb; then
  echo "Verilator build failed"
  exit 1
fi

if ! output=$(./obj_dir/sim_tb +verilator+error+limit+100 2>&1); then
  echo "$output"
  echo "Simulation exited with an error status"
  exit 1
fi
echo "$output"

if echo "$output" | grep -qx "PASS: all tests"; then
  exit 0
else
  exit 1
fi

// File: tests/stream_axi_writer_assertions.sv
`timescale 1ns/10ps

`include "dma_regmap.svh"

module stream_axi_writer_assertions import stream_dma_pkg::*; (
  input logic      clk,
  input logic      rst,
  input logic      reg_wen,
  input reg_addr_t reg_waddr,
  input reg_data_t reg_wdata,
  input logic      in_valid,
  input data_t     in_data,
  input logic      in_credit,
  input addr_t     m_axi_awaddr,
  input logic      m_axi_awvalid,
  input logic      m_axi_awready,
  input data_t     m_axi_wdata,
  input logic      m_axi_wvalid,
  input logic      m_axi_wready,
  input logic      m_axi_bvalid
);

  addr_t     m_base;
  beat_cnt_t m_window;
  logic      m_wrap;
  beat_cnt_t m_offset;
  logic      m_stopped;
  addr_t     exp_addr;
  data_t     exp_data;
  logic      q_empty;
  data_t     data_q [$];
  int        credits;
  int        outstanding;
  logic      aw_fire;
  logic      w_fire;
  logic      bad_addr = 1'b0;
  logic      bad_data = 1'b0;
  logic      bad_aw_hold = 1'b0;
  logic      bad_w_hold = 1'b0;
  logic      bad_stop = 1'b0;
  logic      bad_counts = 1'b0;
  logic      failed;

  assign aw_fire  = m_axi_awvalid && m_axi_awready;
  assign w_fire   = m_axi_wvalid && m_axi_wready;
  assign exp_addr = m_base + addr_t'(m_offset) * addr_t'(BEAT_BYTES);
  assign failed   = bad_addr | bad_data | bad_aw_hold | bad_w_hold | bad_stop | bad_counts;

  always_comb begin
    q_empty  = (data_q.size() == 0);
    exp_data = q_empty ? '0 : data_q[0];
  end

  // ==============================
  // Reference models
  // ==============================
  // Mirror of the window registers and the beat offset the next AW should carry.
  always @(posedge clk) begin
    if (!rst) begin
      m_base      <= '0;
      m_window    <= '0;
      m_wrap      <= 1'b0;
      m_offset    <= '0;
      m_stopped   <= 1'b0;
      credits     <= int'(FIFO_DEPTH);
      outstanding <= 0;
      data_q.delete();
    end else begin
      if (reg_wen && reg_waddr == `DMA_REG_BASE_L) begin
        m_base[31:0] <= reg_wdata;
      end
      if (reg_wen && reg_waddr == `DMA_REG_BASE_H) begin
        m_base[ADDR_W-1:32] <= reg_wdata[ADDR_W-33:0];
      end
      if (reg_wen && reg_waddr == `DMA_REG_WINDOW) begin
        m_window <= reg_wdata[BEAT_W-1:0];
      end
      if (reg_wen && reg_waddr == `DMA_REG_MODE) begin
        m_wrap <= reg_wdata[`DMA_MODE_WRAP];
        if (reg_wdata[`DMA_MODE_EN]) begin
          m_offset  <= '0;
          m_stopped <= 1'b0;
        end
      end else if (aw_fire) begin
        if (int'(m_offset) + 1 >= int'(m_window)) begin
          m_offset  <= '0;
          m_stopped <= !m_wrap;
        end else begin
          m_offset <= m_offset + 1'b1;
        end
      end
      credits     <= credits - int'(in_valid) + int'(in_credit);
      outstanding <= outstanding + int'(aw_fire) - int'(m_axi_bvalid);
      if (in_valid) begin
        data_q.push_back(in_data);
      end
      if (w_fire && !q_empty) begin
        void'(data_q.pop_front());
      end
    end
  end

  // ==============================
  // Checks
  // ==============================
  assert property (@(posedge clk) disable iff (!rst) aw_fire |-> m_axi_awaddr == exp_addr)
    else begin
      bad_addr = 1'b1;
      $error("m_axi_awaddr 0x%h, expected 0x%h", $sampled(m_axi_awaddr), $sampled(exp_addr));
    end

  assert property (@(posedge clk) disable iff (!rst)
                   w_fire |-> (!q_empty && m_axi_wdata == exp_data))
    else begin
      bad_data = 1'b1;
      $error("m_axi_wdata 0x%h, expected 0x%h", $sampled(m_axi_wdata), $sampled(exp_data));
    end

  assert property (@(posedge clk) disable iff (!rst)
                   m_axi_awvalid && !m_axi_awready |=> m_axi_awvalid && $stable(m_axi_awaddr))
    else begin
      bad_aw_hold = 1'b1;
      $error("AW request changed or dropped before its handshake");
    end

  assert property (@(posedge clk) disable iff (!rst)
                   m_axi_wvalid && !m_axi_wready |=> m_axi_wvalid && $stable(m_axi_wdata))
    else begin
      bad_w_hold = 1'b1;
      $error("W beat changed or dropped before its handshake");
    end

  // In stop mode the window is over after window_beats AW handshakes.
  assert property (@(posedge clk) disable iff (!rst) m_stopped |-> !m_axi_awvalid)
    else begin
      bad_stop = 1'b1;
      $error("AW request issued after the window ended in stop mode");
    end

  // A credit that returns in this cycle frees a slot for a beat in the same cycle.
  assert property (@(posedge clk) disable iff (!rst)
                   credits <= int'(FIFO_DEPTH) &&
                   !(in_valid && credits + int'(in_credit) <= 0) &&
                   outstanding <= int'(MAX_OUTSTANDING))
    else begin
      bad_counts = 1'b1;
      $error("credits %0d or outstanding writes %0d out of range", credits, outstanding);
    end

endmodule

// File: tests/tb_stream_axi_writer.sv
`timescale 1ns/10ps

`include "dma_regmap.svh"

module tb_stream_axi_writer import stream_dma_pkg::*; ();

  localparam axi_resp_t  RESP_SLVERR = 2'b10;
  localparam int unsigned WAIT_LIMIT = 4000;

  logic      clk = 1'b0;
  logic      rst;
  logic      reg_wen;
  reg_addr_t reg_waddr;
  reg_data_t reg_wdata;
  logic      reg_ren;
  reg_addr_t reg_raddr;
  reg_data_t reg_rdata;
  logic      in_valid = 1'b0;
  data_t     in_data = '0;
  logic      in_credit;
  addr_t     m_axi_awaddr;
  logic      m_axi_awvalid;
  logic      m_axi_awready = 1'b0;
  data_t     m_axi_wdata;
  logic      m_axi_wvalid;
  logic      m_axi_wready = 1'b0;
  axi_resp_t m_axi_bresp = RESP_OKAY;
  logic      m_axi_bvalid = 1'b0;

  int unsigned credits = FIFO_DEPTH;
  int unsigned beats_req = 0;
  int unsigned beats_sent = 0;
  int unsigned aw_seen = 0;
  int unsigned w_seen = 0;
  int unsigned b_sent = 0;
  data_t       next_word = 64'h0123_4567_0000_0000;

  stream_axi_writer DUT (.*);

  bind stream_axi_writer stream_axi_writer_assertions u_checks (.*);

  always #4 clk = ~clk;

  // ==============================
  // Stream source and AXI slave
  // ==============================
  // A credit that comes back at this edge can be spent right away.
  always @(negedge clk) begin
    int unsigned avail;
    avail = credits + (in_credit ? 1 : 0);
    in_valid <= 1'b0;
    if (rst && beats_sent < beats_req && avail > 0) begin
      in_valid   <= 1'b1;
      in_data    <= next_word;
      next_word  <= next_word + 1'b1;
      beats_sent <= beats_sent + 1;
      avail      = avail - 1;
    end
    credits <= avail;
  end

  // Handshakes are counted here, since valid and the new ready hold until the next rising edge.
  always @(negedge clk) begin
    logic aw_rdy;
    logic w_rdy;
    int unsigned done;
    aw_rdy = ($urandom_range(0, 3) != 0);
    w_rdy  = ($urandom_range(0, 2) != 0);
    done   = (aw_seen < w_seen) ? aw_seen : w_seen;
    m_axi_bvalid <= 1'b0;
    if (rst) begin
      if (m_axi_awvalid && aw_rdy) aw_seen <= aw_seen + 1;
      if (m_axi_wvalid && w_rdy) w_seen <= w_seen + 1;
      if (b_sent < done && $urandom_range(0, 2) == 0) begin
        m_axi_bvalid <= 1'b1;
        m_axi_bresp  <= (b_sent == 6 || b_sent == 17) ? RESP_SLVERR : RESP_OKAY;
        b_sent       <= b_sent + 1;
      end
    end
    m_axi_awready <= aw_rdy;
    m_axi_wready  <= w_rdy;
  end

  always @(negedge clk) begin
    if (DUT.u_checks.failed) abort_run("A concurrent assertion failed.");
  end

  // ==============================
  // Helper tasks
  // ==============================
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("FAIL: see errors above");
    $fatal(1, "Simulation stopped.");
  endtask

  task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
    @(negedge clk);
    reg_wen   = 1'b1;
    reg_waddr = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_wen = 1'b0;
  endtask

  task automatic check_reg(input reg_addr_t addr, input reg_data_t exp, input string name);
    @(negedge clk);
    reg_ren   = 1'b1;
    reg_raddr = addr;
    @(negedge clk);
    reg_ren = 1'b0;
    if (reg_rdata !== exp) begin
      $display("** Error: reg_rdata %s 0x%08h, expected 0x%08h", name, reg_rdata, exp);
      abort_run("Register readback mismatch.");
    end
  endtask

  task automatic write_and_check(input reg_addr_t addr, input reg_data_t data,
                                 input reg_data_t mask, input string name);
    write_reg(addr, data);
    check_reg(addr, data & mask, name);
  endtask

  task automatic wait_responses(input int unsigned target);
    int unsigned cycles;
    cycles = 0;
    while (b_sent < target) begin
      @(posedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) abort_run("Timed out waiting for write responses.");
    end
  endtask

  task automatic wait_credits();
    int unsigned cycles;
    cycles = 0;
    while (credits != FIFO_DEPTH) begin
      @(posedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) abort_run("Timed out waiting for all credits to return.");
    end
  endtask

  // ==============================
  // Test sequence
  // ==============================
  initial begin
    int unsigned seed;
    seed      = $urandom(32'h2f28_56b5);
    rst       = 1'b0;
    reg_wen   = 1'b0;
    reg_waddr = '0;
    reg_wdata = '0;
    reg_ren   = 1'b0;
    reg_raddr = '0;
    repeat (16) @(negedge clk);
    rst = 1'b1;

    // Readback is masked to each register's width. MODE keeps enable clear here.
    write_and_check(`DMA_REG_BASE_L, 32'h1234_5678, 32'hFFFF_FFFF, "BASE_L");
    write_and_check(`DMA_REG_BASE_H, 32'hFFFF_FFFA, 32'h0000_000F, "BASE_H");
    write_and_check(`DMA_REG_WINDOW, 32'hABCD_EF05, 32'h00FF_FFFF, "WINDOW");
    write_and_check(`DMA_REG_MODE, 32'hFFFF_FFFD, 32'h0000_0003, "MODE");

    // Wrap mode over two windows of five beats, with an SLVERR on response 6.
    write_reg(`DMA_REG_BASE_L, 32'h8000_0100);
    write_reg(`DMA_REG_BASE_H, 32'h0000_0003);
    write_reg(`DMA_REG_WINDOW, 32'd5);
    write_reg(`DMA_REG_MODE, 32'h0000_0003);
    beats_req = 10;
    wait_responses(10);
    wait_credits();
    write_reg(`DMA_REG_MODE, 32'h0000_0001);
    check_reg(`DMA_REG_COUNT, 32'd10, "COUNT");
    check_reg(`DMA_REG_STATUS, 32'h1 << `DMA_STATUS_ERR, "STATUS");
    write_reg(`DMA_REG_STATUS, 32'h0);
    check_reg(`DMA_REG_STATUS, 32'h0, "STATUS");

    // Stop mode, with a window that crosses the 4 GiB line.
    // The beats left over fill the FIFO and the producer runs out of credits.
    write_reg(`DMA_REG_BASE_L, 32'hFFFF_FFF0);
    write_reg(`DMA_REG_MODE, 32'h0000_0002);
    beats_req = 23;
    wait_responses(15);
    repeat (40) @(negedge clk);
    check_reg(`DMA_REG_STATUS, 32'h1 << `DMA_STATUS_HALTED, "STATUS");

    // A restart begins again at the base address. Each credit it frees is spent at once.
    write_reg(`DMA_REG_MODE, 32'h0000_0002);
    beats_req = 25;
    wait_responses(20);

    // One more window empties the FIFO.
    write_reg(`DMA_REG_MODE, 32'h0000_0002);
    wait_responses(25);
    wait_credits();
    repeat (4) @(negedge clk);
    check_reg(`DMA_REG_COUNT, 32'd25, "COUNT");
    check_reg(`DMA_REG_STATUS, (32'h1 << `DMA_STATUS_HALTED) | (32'h1 << `DMA_STATUS_ERR),
              "STATUS");

    if (DUT.u_checks.failed) begin
      abort_run("A concurrent assertion failed.");
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

// File: verilog.f
+incdir+include
design/stream_dma_pkg.sv
design/dma_ifs.sv
design/credit_fifo.sv
design/addr_gen.sv
design/axi_wr_issue.sv
design/dma_ctrl.sv
design/stream_axi_writer.sv
tests/stream_axi_writer_assertions.sv
tests/tb_stream_axi_writer.sv
